// File: fletcher_checksum.sv
`timescale 1ns/1ps

module fletcher_checksum (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                add,
    input  img_pkg::word_t      din,
    output img_pkg::checksum_t  dout
);
    logic [15:0] sum1;
    logic [15:0] sum2;
    logic [15:0] sum1_next;
    logic [15:0] sum2_next;

    // Addition modulo 65535
    function automatic logic [15:0] mod_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign sum1_next = mod_add(sum1, din);
    // Second sum accumulates the updated first sum
    assign sum2_next = mod_add(sum2, sum1_next);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (add) begin
            sum1 <= sum1_next;
            sum2 <= sum2_next;
        end
    end

    assign dout = {sum2, sum1};

endmodule

// File: frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
    input  logic            clk,
    input  logic            wr_en,
    input  img_pkg::addr_t  wr_addr,
    input  img_pkg::word_t  wr_data,
    input  logic            rd_en,
    input  img_pkg::addr_t  rd_addr,
    output img_pkg::word_t  rd_data
);
    // One frame of packed pixel words
    img_pkg::word_t mem [img_pkg::pixel_count];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read that holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: img_controller.sv
`timescale 1ns/1ps

module img_controller (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_capture,
    input  logic                cmd_readout,
    input  logic                cmd_skip_count,
    input  img_pkg::header_t    cmd_header,
    input  logic                cmd_thumb,
    input  logic                readout_trigger,
    input  logic                img_fv,
    input  logic                img_lv,
    input  img_pkg::pixel_t     img_d,
    output logic                readout_start,
    output logic                readout_ready,
    output img_pkg::word_t      readout_data,
    output logic                capture_done,
    output img_pkg::count_t     capture_pixel_count,
    output img_pkg::stat_t      capture_highlight_count,
    output img_pkg::stat_t      capture_shadow_count
);
    // Frame buffer ports
    logic               wr_en;
    img_pkg::addr_t     wr_addr;
    img_pkg::word_t     wr_data;
    logic               rd_en;
    img_pkg::addr_t     rd_addr;
    img_pkg::word_t     rd_data;

    // Checksum ports
    logic               checksum_clear;
    logic               checksum_add;
    img_pkg::word_t     checksum_din;
    img_pkg::checksum_t checksum;

    pixel_capture i_pixel_capture (
        .clk                     (clk),
        .reset                   (reset),
        .cmd_capture             (cmd_capture),
        .cmd_skip_count          (cmd_skip_count),
        .img_fv                  (img_fv),
        .img_lv                  (img_lv),
        .img_d                   (img_d),
        .wr_en                   (wr_en),
        .wr_addr                 (wr_addr),
        .wr_data                 (wr_data),
        .capture_done            (capture_done),
        .capture_pixel_count     (capture_pixel_count),
        .capture_highlight_count (capture_highlight_count),
        .capture_shadow_count    (capture_shadow_count)
    );

    frame_buffer i_frame_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fletcher_checksum i_fletcher_checksum (
        .clk   (clk),
        .reset (reset),
        .clear (checksum_clear),
        .add   (checksum_add),
        .din   (checksum_din),
        .dout  (checksum)
    );

    readout_ctrl i_readout_ctrl (
        .clk             (clk),
        .reset           (reset),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .cmd_thumb       (cmd_thumb),
        .readout_trigger (readout_trigger),
        .rd_data         (rd_data),
        .checksum        (checksum),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .rd_en           (rd_en),
        .rd_addr         (rd_addr),
        .checksum_clear  (checksum_clear),
        .checksum_add    (checksum_add),
        .checksum_din    (checksum_din)
    );

endmodule

// File: img_pkg.sv
package img_pkg;

    // ========================================
    // Frame geometry and readout word counts
    // ========================================
    localparam int img_width = 16;
    localparam int img_height = 16;
    localparam int pixel_count = img_width * img_height;

    localparam int header_word_count = 4;
    localparam int checksum_word_count = 2;
    localparam int padding_word_count = 2;

    // Width of the highlight and shadow counters
    localparam int stat_width = 18;

    localparam int addr_width = $clog2(pixel_count);
    localparam int phase_word_total = header_word_count + checksum_word_count +
                                      padding_word_count;

    // ========================================
    // Types
    // ========================================
    typedef logic [11:0] pixel_t;
    typedef logic [15:0] word_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [addr_width:0] count_t;
    typedef logic [stat_width-1:0] stat_t;
    typedef logic [header_word_count*16-1:0] header_t;
    typedef logic [31:0] checksum_t;

    // Readout position within the frame for the thumbnail filter
    typedef logic [$clog2(img_width)-1:0] col_t;
    typedef logic [$clog2(img_height)-1:0] row_t;

    // Words left in a header, checksum or padding phase
    typedef logic [$clog2(phase_word_total)-1:0] phase_count_t;

    typedef enum logic [1:0] {
        cap_idle,
        cap_wait_frame,
        cap_skip_check,
        cap_capture
    } capture_state_t;

    typedef enum logic [2:0] {
        ro_idle,
        ro_header,
        ro_pixels,
        ro_drain,
        ro_checksum,
        ro_padding
    } readout_state_t;

endpackage

// File: pixel_capture.sv
`timescale 1ns/1ps

module pixel_capture (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_capture,
    input  logic                    cmd_skip_count,
    input  logic                    img_fv,
    input  logic                    img_lv,
    input  img_pkg::pixel_t         img_d,
    output logic                    wr_en,
    output img_pkg::addr_t          wr_addr,
    output img_pkg::word_t          wr_data,
    output logic                    capture_done,
    output img_pkg::count_t         capture_pixel_count,
    output img_pkg::stat_t          capture_highlight_count,
    output img_pkg::stat_t          capture_shadow_count
);
    img_pkg::capture_state_t state;

    // Sensor inputs after one register stage
    logic            fv_q;
    logic            lv_q;
    img_pkg::pixel_t d_q;
    logic            fv_prev;
    logic            lv_prev;

    logic            frame_start;
    logic            line_end;
    logic            write_ok;
    logic [1:0]      col;
    logic [1:0]      row;
    logic            skip_count;
    logic            done_pending;
    logic            sample_en;
    img_pkg::pixel_t sample_px;

    assign frame_start = fv_q && !fv_prev;
    assign line_end = lv_prev && !lv_q;

    // Words beyond the end of the buffer are dropped
    assign write_ok = (state == img_pkg::cap_capture) && lv_q &&
                      (capture_pixel_count < img_pkg::count_t'(img_pkg::pixel_count));

    // ========================================
    // Pixel data path
    // ========================================
    always_ff @(posedge clk) begin
        d_q <= img_d;
        // Little-endian word with the low pixel byte first
        wr_data <= {d_q[7:0], 4'b0000, d_q[11:8]};
        wr_addr <= capture_pixel_count[img_pkg::addr_width-1:0];
        sample_px <= d_q;
    end

    // ========================================
    // Frame tracking and capture control
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= img_pkg::cap_idle;
            fv_q <= 1'b0;
            lv_q <= 1'b0;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            col <= '0;
            row <= '0;
            skip_count <= 1'b0;
            wr_en <= 1'b0;
            sample_en <= 1'b0;
            done_pending <= 1'b0;
            capture_done <= 1'b0;
            capture_pixel_count <= '0;
            capture_highlight_count <= '0;
            capture_shadow_count <= '0;
        end else begin
            fv_q <= img_fv;
            lv_q <= img_lv;
            fv_prev <= fv_q;
            lv_prev <= lv_q;
            wr_en <= write_ok;
            done_pending <= 1'b0;
            capture_done <= done_pending;

            // 4x4 sampling grid position
            if (!lv_q) begin
                col <= '0;
            end else begin
                col <= col + 1'b1;
            end
            if (!fv_q) begin
                row <= '0;
            end else if (line_end) begin
                row <= row + 1'b1;
            end

            sample_en <= write_ok && (col == 2'd0) && (row == 2'd0);
            if (write_ok) begin
                capture_pixel_count <= capture_pixel_count + 1'b1;
            end

            // Top seven bits decide highlight or shadow
            if (sample_en) begin
                if (&sample_px[11:5]) begin
                    capture_highlight_count <= capture_highlight_count + 1'b1;
                end else if (sample_px[11:5] == 7'd0) begin
                    capture_shadow_count <= capture_shadow_count + 1'b1;
                end
            end

            case (state)
                img_pkg::cap_wait_frame: begin
                    if (frame_start) begin
                        state <= img_pkg::cap_skip_check;
                    end
                end
                img_pkg::cap_skip_check: begin
                    skip_count <= skip_count - 1'b1;
                    if (skip_count != 1'b0) begin
                        state <= img_pkg::cap_wait_frame;
                    end else begin
                        state <= img_pkg::cap_capture;
                    end
                end
                img_pkg::cap_capture: begin
                    if (!fv_q) begin
                        done_pending <= 1'b1;
                        state <= img_pkg::cap_idle;
                    end
                end
                default: begin
                end
            endcase

            // A new command restarts capture from any state
            if (cmd_capture) begin
                state <= img_pkg::cap_wait_frame;
                skip_count <= cmd_skip_count;
                capture_pixel_count <= '0;
                capture_highlight_count <= '0;
                capture_shadow_count <= '0;
            end
        end
    end

endmodule

// File: project.f
img_pkg.sv
pixel_capture.sv
frame_buffer.sv
fletcher_checksum.sv
readout_ctrl.sv
img_controller.sv
tb_img_controller.sv

// File: readout_ctrl.sv
`timescale 1ns/1ps

module readout_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_readout,
    input  img_pkg::header_t    cmd_header,
    input  logic                cmd_thumb,
    input  logic                readout_trigger,
    input  img_pkg::word_t      rd_data,
    input  img_pkg::checksum_t  checksum,
    output logic                readout_start,
    output logic                readout_ready,
    output img_pkg::word_t      readout_data,
    output logic                rd_en,
    output img_pkg::addr_t      rd_addr,
    output logic                checksum_clear,
    output logic                checksum_add,
    output img_pkg::word_t      checksum_din
);
    img_pkg::readout_state_t state;

    // Shift register and word counter for header, checksum and padding
    img_pkg::header_t        shift;
    img_pkg::phase_count_t   word_count;
    img_pkg::word_t          shift_word;
    logic                    last_word;
    logic                    shift_step;

    // Pixel phase
    logic                    thumb;
    img_pkg::col_t           col;
    img_pkg::row_t           row;
    logic                    keep;
    logic                    issue_done;
    logic                    pend;
    logic                    pend_keep;

    logic                    xfer;
    logic                    out_free;
    img_pkg::checksum_t      checksum_rev;

    assign xfer = readout_ready && readout_trigger;
    // Output register is empty or drains this cycle
    assign out_free = !readout_ready || readout_trigger;

    assign shift_word = shift[$bits(img_pkg::header_t)-1 -: 16];
    assign last_word = (word_count == '0);
    assign shift_step = xfer && !last_word &&
                        (state inside {img_pkg::ro_header, img_pkg::ro_checksum,
                                       img_pkg::ro_padding});

    // Upper-left 2x2 corner of every 8x8 group
    assign keep = !thumb || ((col[2:1] == 2'b00) && (row[2:1] == 2'b00));
    assign rd_en = (state == img_pkg::ro_pixels) && !issue_done && out_free;

    // Checksum sees each accepted header and pixel word byte-swapped
    assign checksum_clear = cmd_readout;
    assign checksum_add = xfer &&
                          ((state == img_pkg::ro_header) || (state == img_pkg::ro_pixels));
    assign checksum_din = {readout_data[7:0], readout_data[15:8]};

    // Four checksum bytes in reversed order
    assign checksum_rev = {checksum[7:0], checksum[15:8], checksum[23:16], checksum[31:24]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= img_pkg::ro_idle;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            word_count <= '0;
            thumb <= 1'b0;
            rd_addr <= '0;
            col <= '0;
            row <= '0;
            issue_done <= 1'b0;
            pend <= 1'b0;
            pend_keep <= 1'b0;
        end else begin
            readout_start <= cmd_readout;

            // ========================================
            // Buffer read issue
            // ========================================
            // rd_data holds a word until it moves to the output register
            pend <= rd_en || (pend && !out_free);
            if (rd_en) begin
                pend_keep <= keep;
                rd_addr <= rd_addr + 1'b1;
                issue_done <= (rd_addr == img_pkg::addr_t'(img_pkg::pixel_count - 1));
                if (col == img_pkg::col_t'(img_pkg::img_width - 1)) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end

            if (shift_step) begin
                readout_data <= shift_word;
                shift <= shift << 16;
                word_count <= word_count - 1'b1;
            end

            // ========================================
            // Phase sequencing
            // ========================================
            case (state)
                img_pkg::ro_header: begin
                    if (xfer && last_word) begin
                        readout_ready <= 1'b0;
                        state <= img_pkg::ro_pixels;
                    end
                end
                img_pkg::ro_pixels: begin
                    if (out_free) begin
                        readout_ready <= 1'b0;
                        if (pend) begin
                            readout_data <= rd_data;
                            readout_ready <= pend_keep;
                        end else if (issue_done) begin
                            state <= img_pkg::ro_drain;
                        end
                    end
                end
                img_pkg::ro_drain: begin
                    readout_data <= checksum_rev[31:16];
                    shift <= {checksum_rev[15:0], {($bits(img_pkg::header_t) - 16){1'b0}}};
                    word_count <= img_pkg::phase_count_t'(img_pkg::checksum_word_count - 1);
                    readout_ready <= 1'b1;
                    state <= img_pkg::ro_checksum;
                end
                img_pkg::ro_checksum: begin
                    if (xfer && last_word) begin
                        readout_data <= '0;
                        word_count <= img_pkg::phase_count_t'(img_pkg::padding_word_count - 1);
                        state <= img_pkg::ro_padding;
                    end
                end
                img_pkg::ro_padding: begin
                    if (xfer && last_word) begin
                        readout_ready <= 1'b0;
                        state <= img_pkg::ro_idle;
                    end
                end
                default: begin
                end
            endcase

            // Restart presents the first header word on the next cycle
            if (cmd_readout) begin
                readout_data <= cmd_header[$bits(img_pkg::header_t)-1 -: 16];
                shift <= cmd_header << 16;
                word_count <= img_pkg::phase_count_t'(img_pkg::header_word_count - 1);
                readout_ready <= 1'b1;
                thumb <= cmd_thumb;
                rd_addr <= '0;
                col <= '0;
                row <= '0;
                issue_done <= 1'b0;
                pend <= 1'b0;
                state <= img_pkg::ro_header;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_img_controller \
    -f project.f -o sim_tb &&
./obj_dir/sim_tb 2>&1 | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_img_controller.sv
`timescale 1ns/1ps

module tb_img_controller;

    // ========================================
    // Timing of the sensor model and limits
    // ========================================
    localparam int clk_period = 10;
    localparam int reset_cycles = 16;
    localparam int idle_cycles = 20;
    localparam int frame_lead = 4;
    localparam int line_blank = 3;
    localparam int frame_tail = 8;
    localparam int frame_cycles = frame_lead + frame_tail +
                                  img_pkg::img_height * (img_pkg::img_width + line_blank);
    // Generous bound for one readout under back-pressure
    localparam int readout_cycles = 4 * (img_pkg::pixel_count + img_pkg::phase_word_total);
    localparam int frame_total = 3;
    localparam int readout_total = 3;
    localparam int watchdog_cycles = reset_cycles + idle_cycles +
                                     2 * (frame_total * frame_cycles +
                                          readout_total * readout_cycles);

    logic                   clk;
    logic                   reset;
    logic                   cmd_capture;
    logic                   cmd_readout;
    logic                   cmd_skip_count;
    img_pkg::header_t       cmd_header;
    logic                   cmd_thumb;
    logic                   readout_trigger;
    logic                   img_fv;
    logic                   img_lv;
    img_pkg::pixel_t        img_d;
    logic                   readout_start;
    logic                   readout_ready;
    img_pkg::word_t         readout_data;
    logic                   capture_done;
    img_pkg::count_t        capture_pixel_count;
    img_pkg::stat_t         capture_highlight_count;
    img_pkg::stat_t         capture_shadow_count;

    // Pixels of the frame the DUT is expected to hold
    img_pkg::pixel_t frame_model [img_pkg::pixel_count];
    int done_count = 0;

    img_controller i_img_controller (
        .clk                     (clk),
        .reset                   (reset),
        .cmd_capture             (cmd_capture),
        .cmd_readout             (cmd_readout),
        .cmd_skip_count          (cmd_skip_count),
        .cmd_header              (cmd_header),
        .cmd_thumb               (cmd_thumb),
        .readout_trigger         (readout_trigger),
        .img_fv                  (img_fv),
        .img_lv                  (img_lv),
        .img_d                   (img_d),
        .readout_start           (readout_start),
        .readout_ready           (readout_ready),
        .readout_data            (readout_data),
        .capture_done            (capture_done),
        .capture_pixel_count     (capture_pixel_count),
        .capture_highlight_count (capture_highlight_count),
        .capture_shadow_count    (capture_shadow_count)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        if (!reset && capture_done) begin
            done_count++;
        end
    end

    // ========================================
    // Checking helpers
    // ========================================
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            abort_run();
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    // Some pixels get forced highlight or shadow tops
    function automatic img_pkg::pixel_t random_pixel();
        logic [31:0] r;
        r = $urandom;
        case (r[31:30])
            2'd0: return {7'h7f, r[4:0]};
            2'd1: return {7'h00, r[4:0]};
            default: return r[11:0];
        endcase
    endfunction

    function automatic img_pkg::word_t pack_pixel(input img_pkg::pixel_t px);
        return {px[7:0], 4'b0000, px[11:8]};
    endfunction

    function automatic logic thumb_keeps(input int addr);
        int col;
        int row;
        col = addr % img_pkg::img_width;
        row = addr / img_pkg::img_width;
        return ((col % 8) < 2) && ((row % 8) < 2);
    endfunction

    task automatic fletcher_step(inout int s1, inout int s2, input img_pkg::word_t w);
        s1 = (s1 + {w[7:0], w[15:8]}) % 65535;
        s2 = (s2 + s1) % 65535;
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic send_frame(input logic store);
        img_pkg::pixel_t px;
        int r;
        int c;
        img_fv = 1'b1;
        repeat (frame_lead) @(negedge clk);
        for (r = 0; r < img_pkg::img_height; r++) begin
            for (c = 0; c < img_pkg::img_width; c++) begin
                px = random_pixel();
                if (store) begin
                    frame_model[r * img_pkg::img_width + c] = px;
                end
                img_lv = 1'b1;
                img_d = px;
                @(negedge clk);
            end
            // Junk on the data bus while the line is blanked
            img_lv = 1'b0;
            img_d = random_pixel();
            repeat (line_blank) @(negedge clk);
        end
        img_fv = 1'b0;
        repeat (frame_tail) @(negedge clk);
    endtask

    task automatic capture_frame(input logic skip);
        int done_before;
        int highlights;
        int shadows;
        int r;
        int c;
        img_pkg::pixel_t px;
        done_before = done_count;
        cmd_capture = 1'b1;
        cmd_skip_count = skip;
        @(negedge clk);
        cmd_capture = 1'b0;
        if (skip) begin
            send_frame(1'b0);
        end
        send_frame(1'b1);
        require(done_count == done_before + 1,
                $sformatf("capture_done pulsed %0d times instead of once",
                          done_count - done_before));

        highlights = 0;
        shadows = 0;
        for (r = 0; r < img_pkg::img_height; r += 4) begin
            for (c = 0; c < img_pkg::img_width; c += 4) begin
                px = frame_model[r * img_pkg::img_width + c];
                if (&px[11:5]) begin
                    highlights++;
                end else if (px[11:5] == 7'd0) begin
                    shadows++;
                end
            end
        end
        compare_value("capture_pixel_count", capture_pixel_count, img_pkg::pixel_count);
        compare_value("capture_highlight_count", capture_highlight_count, highlights);
        compare_value("capture_shadow_count", capture_shadow_count, shadows);
    endtask

    task automatic read_frame(input logic thumb);
        img_pkg::header_t hdr;
        img_pkg::word_t exp_q [$];
        img_pkg::word_t w;
        img_pkg::word_t last_data;
        logic last_held;
        logic trig;
        logic [31:0] csum;
        int sum1;
        int sum2;
        int a;
        int step;

        sum1 = 0;
        sum2 = 0;
        hdr = {$urandom, $urandom};
        for (a = 0; a < img_pkg::header_word_count; a++) begin
            w = hdr[$bits(img_pkg::header_t) - 1 - 16 * a -: 16];
            exp_q.push_back(w);
            fletcher_step(sum1, sum2, w);
        end
        for (a = 0; a < img_pkg::pixel_count; a++) begin
            if (!thumb || thumb_keeps(a)) begin
                w = pack_pixel(frame_model[a]);
                exp_q.push_back(w);
                fletcher_step(sum1, sum2, w);
            end
        end
        // Checksum bytes go out in reversed order
        csum = {sum2[15:0], sum1[15:0]};
        exp_q.push_back({csum[7:0], csum[15:8]});
        exp_q.push_back({csum[23:16], csum[31:24]});
        for (a = 0; a < img_pkg::padding_word_count; a++) begin
            exp_q.push_back('0);
        end

        cmd_header = hdr;
        cmd_thumb = thumb;
        cmd_readout = 1'b1;
        @(negedge clk);
        cmd_readout = 1'b0;
        require(readout_start, "readout_start did not pulse after the readout command");

        step = 0;
        last_held = 1'b0;
        last_data = '0;
        while (exp_q.size() > 0) begin
            if (step > 0) begin
                @(negedge clk);
                require(!readout_start, "readout_start pulsed more than once");
            end
            if (last_held) begin
                compare_value("readout_data", readout_data, last_data);
            end
            // Consumer accepts about three cycles in four
            trig = ($urandom % 4) != 0;
            readout_trigger = trig;
            if (readout_ready && trig) begin
                compare_value("readout_data", readout_data, exp_q.pop_front());
            end
            last_held = readout_ready && !trig;
            last_data = readout_data;
            step++;
        end
        @(negedge clk);
        readout_trigger = 1'b0;
        require(!readout_ready, "readout_ready stayed high after the last padding word");
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired before all tests finished");
        abort_run();
    end

    initial begin
        void'($urandom(32'h646d_34e4));
        clk = 1'b0;
        reset = 1'b1;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_skip_count = 1'b0;
        cmd_header = '0;
        cmd_thumb = 1'b0;
        readout_trigger = 1'b0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        img_d = '0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        // Nothing moves before the first command
        repeat (idle_cycles) begin
            @(negedge clk);
            require(!readout_ready && !readout_start && !capture_done,
                    "Outputs became active without a command");
        end

        capture_frame(1'b0);
        read_frame(1'b0);
        capture_frame(1'b1);
        read_frame(1'b0);
        read_frame(1'b1);

        $display("TEST PASS");
        $finish;
    end

endmodule
